//--- sim.f
source/rv_isa_pkg.sv
source/hart_cfg_pkg.sv
source/decode_if.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/hart.sv
testbench/tb_clock.sv
testbench/hart_tb.sv

//--- testbench/hart_tb.sv
/* Random forward-only programs over x0..x7, checked per retire against an ISA model.
   Run one ends in a store epilogue and EBREAK, run two traps on an illegal word. */

`timescale 1ns/10ps
`default_nettype none

module hart_tb
    import hart_cfg_pkg::*, rv_isa_pkg::*;
();

    localparam int PROG_WORDS = 256;
    localparam int DMEM_WORDS = 64;
    localparam int EPI_START  = PROG_WORDS - 8;    // SW x1..x7, then EBREAK
    localparam int EPI_DATA   = 56;                // Data words holding the x1..x7 dump
    localparam int MAX_STEPS  = 300;               // Forward-only code retires < 256
    localparam int SAMPLE_DLY = 25;                // ns after the falling edge
    localparam int HOLD_CHECK = 4;

    logic clk, rst, dmem_ren, dmem_wen, ret_valid, ret_trap, ret_halt;
    word_t imem_raddr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    word_t ret_inst, ret_wdata, ret_pc, ret_next_pc;
    reg_addr_t ret_waddr;
    logic [31:0] imem [0:PROG_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] m_regs [0:31];                    // Reference model state
    logic [31:0] m_mem [0:DMEM_WORDS-1];
    logic [31:0] m_pc, e_pc, e_inst, e_next, e_wdata, e_addr, e_sdata;
    logic [4:0]  e_rd;
    bit          e_store, e_load, e_trap, e_halt;
    integer      seed;

    tb_clock clock_i (.o_clk(clk));

    hart dut_i (
        .i_clk (clk), .i_rst (rst),
        .o_imem_raddr (imem_raddr), .i_imem_rdata (imem_rdata),
        .o_dmem_addr (dmem_addr), .o_dmem_ren (dmem_ren), .o_dmem_wen (dmem_wen),
        .o_dmem_wdata (dmem_wdata), .i_dmem_rdata (dmem_rdata),
        .o_retire_valid (ret_valid), .o_retire_inst (ret_inst),
        .o_retire_trap (ret_trap), .o_retire_halt (ret_halt),
        .o_retire_rd_waddr (ret_waddr), .o_retire_rd_wdata (ret_wdata),
        .o_retire_pc (ret_pc), .o_retire_next_pc (ret_next_pc)
    );

    // Memory models, combinational reads
    assign imem_rdata = imem[imem_raddr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];
    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;    // Store lands on the edge
        end
    end

    // ============================================================
    // Instruction encoders and random program
    // ============================================================
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic int fwd_target(int idx, logic [3:0] r);
        return (idx + 1 + int'(r) > EPI_START) ? EPI_START : idx + 1 + int'(r);
    endfunction

    function automatic logic [31:0] illegal_word(logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h0000_0000;                                // Unknown opcode
            2'd1:    return enc_i(12'h0, 5'd0, 3'b001, 5'd1, OPC_LOAD);   // LH
            2'd2:    return enc_s(12'h0, 5'd1, 5'd0, 3'b000);             // SB
            default: return 32'h0000_0073;                                // ECALL
        endcase
    endfunction

    function automatic logic [31:0] gen_body_word(int idx, bit with_illegal);
        logic [31:0] r, r2;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [20:0] off;
        r   = next_rand();
        r2  = next_rand();
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        alt = r[16] && (f3 == F3_ADD_SUB || f3 == F3_SR);     // SUB / SRA
        off = 21'((fwd_target(idx, r2[3:0]) - idx) * 4);
        case (r[15:12])
            4'd0, 4'd1, 4'd2: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
            4'd3, 4'd4, 4'd5: begin
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    return enc_i({1'b0, alt, 5'b0, r2[4:0]}, rs1, f3, rd, OPC_OP_IMM);
                end
                return enc_i(r2[11:0], rs1, f3, rd, OPC_OP_IMM);
            end
            4'd6:  return {r2[19:0], rd, OPC_LUI};
            4'd7:  return {r2[19:0], rd, OPC_AUIPC};
            4'd8:  return enc_i({4'b0, r2[5:0], 2'b0}, 5'd0, F3_WORD, rd, OPC_LOAD);
            4'd9:  return enc_s({4'b0, 6'(r2[5:0] % EPI_DATA), 2'b0}, rs2, 5'd0, F3_WORD);
            4'd10, 4'd11: begin
                f3 = (f3 % 6 < 2) ? f3 % 6 : f3 % 6 + 3'd2;          // Skip 010, 011
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
            end
            4'd12: return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
            4'd13: return enc_i(12'(fwd_target(idx, r2[3:0]) * 4), 5'd0, 3'b000, rd, OPC_JALR);
            default: begin
                if (with_illegal && r2[31:29] == 3'b0) begin
                    return illegal_word(r2[5:4]);
                end
                return enc_i(r2[11:0], rs1, F3_ADD_SUB, rd, OPC_OP_IMM);
            end
        endcase
    endfunction

    // ============================================================
    // Reference ISA model
    // ============================================================
    function automatic logic [31:0] alu_ref(logic [2:0] f3, bit alt, logic [31:0] a, b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    return {31'b0, a < b};
            F3_XOR:     return a ^ b;
            F3_SR: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(logic [2:0] f3, logic [31:0] a, b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic model_step();
        logic [31:0] a, b, i_imm, s_imm, wval;
        logic [2:0]  f3;
        bit          wen;
        e_pc   = m_pc;
        e_inst = imem[m_pc[9:2]];
        f3     = e_inst[14:12];
        a      = m_regs[e_inst[19:15]];
        b      = m_regs[e_inst[24:20]];
        i_imm  = {{20{e_inst[31]}}, e_inst[31:20]};
        s_imm  = {{20{e_inst[31]}}, e_inst[31:25], e_inst[11:7]};
        e_next = m_pc + 32'd4;
        {wen, e_store, e_load, e_trap, e_halt} = '0;
        wval   = '0;
        case (e_inst[6:0])
            OPC_OP:     {wen, wval} = {1'b1, alu_ref(f3, e_inst[30], a, b)};
            OPC_OP_IMM: {wen, wval} = {1'b1, alu_ref(f3, e_inst[30] && f3 == F3_SR, a, i_imm)};
            OPC_LOAD: begin
                e_trap = (f3 != F3_WORD);
                {wen, e_load} = 2'b11;
                wval = m_mem[(a + i_imm) >> 2 & 32'h3f];
            end
            OPC_STORE: begin
                e_trap  = (f3 != F3_WORD);
                e_store = 1'b1;
                e_addr  = (a + s_imm) & ~32'h3;
                e_sdata = b;
            end
            OPC_BRANCH: begin
                if (branch_ref(f3, a, b)) begin   // B-type offset
                    e_next = m_pc + {{19{e_inst[31]}}, e_inst[31], e_inst[7],
                                     e_inst[30:25], e_inst[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                {wen, wval} = {1'b1, m_pc + 32'd4};
                e_next = m_pc + {{11{e_inst[31]}}, e_inst[31], e_inst[19:12], e_inst[20],
                                 e_inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                {wen, wval} = {1'b1, m_pc + 32'd4};
                e_next = (a + i_imm) & ~32'h1;
            end
            OPC_LUI:    {wen, wval} = {1'b1, e_inst[31:12], 12'b0};
            OPC_AUIPC:  {wen, wval} = {1'b1, m_pc + {e_inst[31:12], 12'b0}};
            OPC_SYSTEM: begin
                e_halt = (e_inst == EBREAK_WORD);
                e_trap = !e_halt;
            end
            default:    e_trap = 1'b1;
        endcase
        if (e_trap) begin                        // No effect from a trapping word
            {wen, e_store, e_load, e_halt} = 4'b0001;
        end
        if (e_halt) begin
            e_next = m_pc;
        end
        e_rd    = (wen && e_inst[11:7] != 5'd0) ? e_inst[11:7] : 5'd0;
        e_wdata = (e_rd != 5'd0) ? wval : '0;
        if (e_rd != 5'd0) begin
            m_regs[e_rd] = wval;
        end
        if (e_store) begin
            m_mem[e_addr[7:2]] = e_sdata;
        end
        m_pc = e_next;
    endtask

    // ============================================================
    // Checks and run control
    // ============================================================
    task automatic check_eq(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s actual %h expected %h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic next_sample();
        @(negedge clk);
        #SAMPLE_DLY;                             // Outputs settled, edge far away
    endtask

    task automatic check_retire();
        check_eq("o_retire_valid", ret_valid, 1'b1);
        check_eq("o_imem_raddr", imem_raddr, e_pc);
        check_eq("o_retire_pc", ret_pc, e_pc);
        check_eq("o_retire_inst", ret_inst, e_inst);
        check_eq("o_retire_rd_waddr", ret_waddr, e_rd);
        check_eq("o_retire_rd_wdata", ret_wdata, e_wdata);
        check_eq("o_retire_next_pc", ret_next_pc, e_next);
        check_eq("o_retire_trap", ret_trap, e_trap);
        check_eq("o_retire_halt", ret_halt, e_halt);
        check_eq("o_dmem_wen", dmem_wen, e_store);
        check_eq("o_dmem_ren", dmem_ren, e_load);
        if (e_store) begin
            check_eq("o_dmem_addr", dmem_addr, e_addr);
            check_eq("o_dmem_wdata", dmem_wdata, e_sdata);
        end
    endtask

    task automatic run_program(bit with_illegal);
        int steps;
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < EPI_START; i++) begin
            imem[i] = gen_body_word(i, with_illegal);
        end
        for (int i = 1; i < 8; i++) begin       // Dump x1..x7 for the final compare
            imem[EPI_START+i-1] = enc_s(12'((EPI_DATA + i - 1) * 4), 5'(i), 5'd0, F3_WORD);
        end
        imem[PROG_WORDS-1] = EBREAK_WORD;
        if (with_illegal) begin
            imem[EPI_START] = illegal_word(2'd1);   // Trap before the epilogue
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]  = 32'hC0DE_0000 ^ (i * 32'h0101_0107);
            m_mem[i] = 32'hC0DE_0000 ^ (i * 32'h0101_0107);
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc = RESET_ADDR;
        for (int i = 0; i < 16; i++) begin      // Reset cycles, nothing retires
            #SAMPLE_DLY;
            check_eq("o_retire_valid", ret_valid, 1'b0);
            check_eq("o_dmem_wen", dmem_wen, 1'b0);
            check_eq("o_dmem_ren", dmem_ren, 1'b0);
            @(negedge clk);
        end
        rst = 1'b0;
        #SAMPLE_DLY;
        check_eq("o_retire_pc", ret_pc, RESET_ADDR);
        steps = 0;
        e_halt = 1'b0;
        while (!e_halt) begin
            if (steps >= MAX_STEPS) begin
                $display("timeout: hart did not halt within %0d instructions", MAX_STEPS);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
            model_step();
            check_retire();
            steps++;
            if (!e_halt) begin
                next_sample();
            end
        end
        repeat (HOLD_CHECK) begin               // Halted word keeps retiring in place
            next_sample();
            check_retire();
        end
        if (!with_illegal) begin
            for (int i = 1; i < 8; i++) begin
                check_eq("epilogue register dump", dmem[EPI_DATA+i-1], m_regs[i]);
            end
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            check_eq("dmem", dmem[i], m_mem[i]);
        end
    endtask

    initial begin
        seed = 32'h722fcbff;
        rst  = 1'b1;
        run_program(1'b0);                      // Clean program, ends in EBREAK
        run_program(1'b1);                      // Illegal words, ends in a trap
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
/* Free-running simulation clock, 100 ns period, starts low */

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic o_clk
);

    localparam int HALF_PERIOD = 50;    // ns

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- source/hart.sv
/* Single-cycle RV32I hart, combinational imem/dmem reads, dmem write on the edge.
   Low two address bits are dropped, no misalignment traps. After a trap or EBREAK
   the PC holds and the same instruction retires every cycle. */

`timescale 1ns/10ps
`default_nettype none

module hart
    import hart_cfg_pkg::*, rv_isa_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,              // Synchronous, active high

    // Instruction port
    output word_t      o_imem_raddr,
    input  wire word_t i_imem_rdata,

    // Data port, word access only
    output word_t      o_dmem_addr,
    output logic       o_dmem_ren,
    output logic       o_dmem_wen,
    output word_t      o_dmem_wdata,
    input  wire word_t i_dmem_rdata,

    // Retire port, one instruction per cycle
    output logic       o_retire_valid,
    output word_t      o_retire_inst,
    output logic       o_retire_trap,
    output logic       o_retire_halt,
    output reg_addr_t  o_retire_rd_waddr,  // Zero when nothing written
    output word_t      o_retire_rd_wdata,
    output word_t      o_retire_pc,
    output word_t      o_retire_next_pc
);

    word_t        pc;
    word_t        next_pc;
    word_t        pc_plus_4;
    word_t        pc_plus_imm;         // Branch/JAL target and AUIPC value
    inst_fields_t f;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        alu_op2;
    word_t        alu_result;
    logic         br_true;
    word_t        wb_data;
    logic         rd_wen;

    assign f = i_imem_rdata;

    decode_if ctl_if ();

    decoder decoder_i (
        .i_inst (i_imem_rdata),
        .ctl    (ctl_if.dec_mp)
    );

    // ============================================================
    // Register file and execute
    // ============================================================
    assign rd_wen = ctl_if.reg_write & ~i_rst;   // Decoder already clears it on trap

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (f.rs1),
        .i_rs2_addr (f.rs2),
        .i_rd_addr  (f.rd),
        .i_rd_data  (wb_data),
        .i_rd_wen   (rd_wen),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign alu_op2 = ctl_if.op2_is_imm ? ctl_if.imm : rs2_data;

    alu alu_i (
        .ctl       (ctl_if.alu_mp),
        .i_op1     (rs1_data),
        .i_op2     (alu_op2),
        .o_result  (alu_result),
        .o_br_true (br_true)
    );

    // ============================================================
    // Program counter
    // ============================================================
    assign pc_plus_4   = pc + word_t'(4);
    assign pc_plus_imm = pc + ctl_if.imm;

    always_comb begin
        if (ctl_if.halt) begin
            next_pc = pc;                                  // Hold on EBREAK / trap
        end else if (ctl_if.is_jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};        // rs1 + imm, bit 0 cleared
        end else if (ctl_if.is_jal || (ctl_if.is_branch && br_true)) begin
            next_pc = pc_plus_imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_imem_raddr = pc;

    // Data port, address is rs1 + imm word aligned
    assign o_dmem_addr  = {alu_result[XLEN-1:2], 2'b00};
    assign o_dmem_ren   = ctl_if.mem_read & ~i_rst;
    assign o_dmem_wen   = ctl_if.mem_write & ~i_rst;
    assign o_dmem_wdata = rs2_data;

    // Writeback select
    always_comb begin
        case (ctl_if.wb_sel)
            WB_MEM:    wb_data = i_dmem_rdata;
            WB_PC4:    wb_data = pc_plus_4;
            WB_IMM:    wb_data = ctl_if.imm;
            WB_PC_IMM: wb_data = pc_plus_imm;
            default:   wb_data = alu_result;
        endcase
    end

    // ============================================================
    // Retire
    // ============================================================
    assign o_retire_valid    = ~i_rst;
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_trap     = ctl_if.trap;
    assign o_retire_halt     = ctl_if.halt;
    assign o_retire_rd_waddr = ctl_if.reg_write ? f.rd : '0;
    assign o_retire_rd_wdata = (o_retire_rd_waddr != '0) ? wb_data : '0;   // x0 reads zero
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = next_pc;

endmodule

`default_nettype wire

//--- source/alu.sv
/* Combinational ALU and branch compare. o_br_true is only meaningful for a
   branch; reserved branch funct3 codes give not-taken. */

`timescale 1ns/10ps
`default_nettype none

module alu
    import hart_cfg_pkg::*, rv_isa_pkg::*;
(
    decode_if.alu_mp   ctl,
    input  wire word_t i_op1,
    input  wire word_t i_op2,
    output word_t      o_result,
    output logic       o_br_true
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;           // Signed less-than
    logic       lt_u;           // Unsigned less-than

    assign shamt = i_op2[4:0];  // Upper bits ignored for shifts
    assign eq    = (i_op1 == i_op2);
    assign lt_s  = ($signed(i_op1) < $signed(i_op2));
    assign lt_u  = (i_op1 < i_op2);

    // ============================================================
    // Result
    // ============================================================
    always_comb begin
        case (ctl.alu_op)
            ALU_ADD:  o_result = i_op1 + i_op2;
            ALU_SUB:  o_result = i_op1 - i_op2;
            ALU_SLL:  o_result = i_op1 << shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  o_result = i_op1 ^ i_op2;
            ALU_SRL:  o_result = i_op1 >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_op1) >>> shamt);
            ALU_OR:   o_result = i_op1 | i_op2;
            ALU_AND:  o_result = i_op1 & i_op2;
            default:  o_result = '0;
        endcase
    end

    // Branch condition from the three compares
    always_comb begin
        case (ctl.br_cond)
            F3_BEQ:  o_br_true = eq;
            F3_BNE:  o_br_true = ~eq;
            F3_BLT:  o_br_true = lt_s;
            F3_BGE:  o_br_true = ~lt_s;
            F3_BLTU: o_br_true = lt_u;
            F3_BGEU: o_br_true = ~lt_u;
            default: o_br_true = 1'b0;  // funct3 010 / 011
        endcase
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
/* x1..x31 in flops, x0 reads as zero. Reads are combinational and a write
   shows up on the read ports only in the next cycle (no bypass). */

`timescale 1ns/10ps
`default_nettype none

module reg_file
    import hart_cfg_pkg::*, rv_isa_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_rst,
    input  wire reg_addr_t i_rs1_addr,
    input  wire reg_addr_t i_rs2_addr,
    input  wire reg_addr_t i_rd_addr,
    input  wire word_t     i_rd_data,
    input  wire            i_rd_wen,
    output word_t          o_rs1_data,
    output word_t          o_rs2_data
);

    word_t regs [1:NUM_REGS-1];     // No storage for x0

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin   // x0 writes dropped
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- source/decoder.sv
/* Purely combinational decode. Sub-word loads/stores, ECALL and any other
   SYSTEM word decode as traps. JALR funct3 and funct7 of ALU ops are not checked. */

`timescale 1ns/10ps
`default_nettype none

module decoder
    import hart_cfg_pkg::*, rv_isa_pkg::*;
(
    input  wire word_t i_inst,
    decode_if.dec_mp   ctl
);

    inst_fields_t f;
    imm_fmt_e     imm_fmt;
    alu_op_e      arith_op;     // funct3 mapping for OP / OP_IMM
    logic         illegal;
    logic         ebreak;

    assign f = i_inst;

    // ============================================================
    // ALU operation from funct3 and funct7[5]
    // ============================================================
    always_comb begin
        case (f.funct3)
            F3_ADD_SUB: arith_op = (f.opcode == OPC_OP && f.funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = f.funct7[5] ? ALU_SRA : ALU_SRL;   // Both formats
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    // ============================================================
    // Main control
    // ============================================================
    always_comb begin
        ctl.alu_op     = ALU_ADD;        // Address / target sum by default
        ctl.op2_is_imm = 1'b1;
        ctl.wb_sel     = WB_ALU;
        ctl.reg_write  = 1'b0;
        ctl.mem_read   = 1'b0;
        ctl.mem_write  = 1'b0;
        ctl.is_branch  = 1'b0;
        ctl.br_cond    = branch_f3_e'(f.funct3);
        ctl.is_jal     = 1'b0;
        ctl.is_jalr    = 1'b0;
        imm_fmt        = IMM_I;
        illegal        = 1'b0;
        ebreak         = 1'b0;

        case (f.opcode)
            OPC_OP: begin
                ctl.alu_op     = arith_op;
                ctl.op2_is_imm = 1'b0;
                ctl.reg_write  = 1'b1;
            end
            OPC_OP_IMM: begin
                ctl.alu_op    = arith_op;
                ctl.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                ctl.wb_sel    = WB_MEM;
                ctl.reg_write = 1'b1;
                ctl.mem_read  = 1'b1;
                illegal       = (f.funct3 != F3_WORD);    // LB/LH/LBU/LHU dropped
            end
            OPC_STORE: begin
                imm_fmt       = IMM_S;
                ctl.mem_write = 1'b1;
                illegal       = (f.funct3 != F3_WORD);    // SB/SH dropped
            end
            OPC_BRANCH: begin
                imm_fmt        = IMM_B;
                ctl.alu_op     = ALU_SUB;                 // Result unused, compare only
                ctl.op2_is_imm = 1'b0;                    // rs1 vs rs2
                ctl.is_branch  = 1'b1;
            end
            OPC_JAL: begin
                imm_fmt       = IMM_J;
                ctl.wb_sel    = WB_PC4;
                ctl.reg_write = 1'b1;
                ctl.is_jal    = 1'b1;
            end
            OPC_JALR: begin
                ctl.wb_sel    = WB_PC4;
                ctl.reg_write = 1'b1;
                ctl.is_jalr   = 1'b1;
            end
            OPC_LUI: begin
                imm_fmt       = IMM_U;
                ctl.wb_sel    = WB_IMM;
                ctl.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                imm_fmt       = IMM_U;
                ctl.wb_sel    = WB_PC_IMM;
                ctl.reg_write = 1'b1;
            end
            OPC_SYSTEM: begin
                ebreak  = (i_inst == EBREAK_WORD);
                illegal = (i_inst != EBREAK_WORD);        // ECALL, CSRs, WFI...
            end
            default: illegal = 1'b1;                      // Unknown opcode
        endcase

        // A trapping instruction must leave no architectural effect
        if (illegal) begin
            ctl.reg_write = 1'b0;
            ctl.mem_read  = 1'b0;
            ctl.mem_write = 1'b0;
        end
        ctl.trap = illegal;
        ctl.halt = illegal | ebreak;
    end

    // ============================================================
    // Immediate generation, all sign-extended from bit 31
    // ============================================================
    always_comb begin
        case (imm_fmt)
            IMM_S:   ctl.imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            IMM_B:   ctl.imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                i_inst[30:25], i_inst[11:8], 1'b0};
            IMM_U:   ctl.imm = {i_inst[31:12], 12'b0};
            IMM_J:   ctl.imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                                i_inst[20], i_inst[30:21], 1'b0};
            default: ctl.imm = {{20{i_inst[31]}}, i_inst[31:20]};     // I-type
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_if.sv
/* Decoded control of the current instruction, valid in the same cycle.
   Enables are already cleared by the decoder on a trap. */

`timescale 1ns/10ps
`default_nettype none

interface decode_if
    import hart_cfg_pkg::*, rv_isa_pkg::*;
();

    alu_op_e    alu_op;
    logic       op2_is_imm;     // ALU operand 2 from imm instead of rs2
    word_t      imm;            // Sign-extended immediate
    wb_sel_e    wb_sel;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    branch_f3_e br_cond;
    logic       is_jal;
    logic       is_jalr;
    logic       trap;           // Illegal encoding
    logic       halt;           // EBREAK or trap

    modport dec_mp (output alu_op, op2_is_imm, imm, wb_sel, reg_write, mem_read,
                    mem_write, is_branch, br_cond, is_jal, is_jalr, trap, halt);

    modport alu_mp (input alu_op, br_cond);

    modport dp_mp (input op2_is_imm, imm, wb_sel, reg_write, mem_read, mem_write,
                   is_branch, is_jal, is_jalr, trap, halt);

endinterface

`default_nettype wire

//--- source/hart_cfg_pkg.sv
/* Datapath widths and internal control encodings of the hart.
   Reset address is fixed at zero; no per-instance override. */

`default_nettype none

package hart_cfg_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;              // Including x0

    typedef logic [XLEN-1:0] word_t;

    localparam word_t RESET_ADDR = '0;         // First fetch address

    // ============================================================
    // Decoded control encodings
    // ============================================================
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // Register writeback source
    typedef enum logic [2:0] {
        WB_ALU,                                // ALU result
        WB_MEM,                                // Load data
        WB_PC4,                                // Link address for JAL/JALR
        WB_IMM,                                // LUI
        WB_PC_IMM                              // AUIPC
    } wb_sel_e;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
/* RV32I encodings for the supported subset only: word loads and stores, no CSR
   or FENCE. Enum literals carry prefixes so both packages can be imported together. */

`default_nettype none

package rv_isa_pkg;

    // ============================================================
    // Major opcodes, bits [6:0]
    // ============================================================
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // Register-register ALU
        OPC_OP_IMM = 7'b0010011,    // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011     // Only EBREAK is accepted
    } opcode_e;

    // Branch conditions, funct3 of BRANCH
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // ALU function, funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,        // funct7[5] picks SUB on OP only
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,        // funct7[5] picks SRA
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    localparam logic [2:0]  F3_WORD     = 3'b010;           // LW / SW
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef logic [4:0] reg_addr_t;

    // R-type field layout, shared by all formats for rd/rs1/rs2/funct3
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_fields_t;

endpackage

`default_nettype wire
